// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_igr_dpc
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: rtl/igr_dpc_top.sv
//--------------------------------------------------------------------------
// ingress data path and pause control between port logic and packet buffer
// receive path and pause path are independent, i_rx_ecc is not checked
//--------------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module igr_dpc_top (
  input  logic                                                 i_cclk,
  input  logic                                                 i_rst,
  // ------------------------------------------------------------------------
  // port logic receive word
  // ------------------------------------------------------------------------
  input  logic [igr_pkg::PORT_W-1:0]                           i_rx_port_num,
  input  logic [igr_pkg::DATA_BYTES-1:0]                       i_rx_data_v,
  input  logic [igr_pkg::DATA_W-1:0]                           i_rx_data,
  input  logic                                                 i_rx_sop,
  input  logic                                                 i_rx_eop,
  input  logic                                                 i_rx_err,
  input  logic [igr_pkg::TC_W-1:0]                             i_rx_tc,
  input  logic [igr_pkg::TS_W-1:0]                             i_rx_ts,
  // ecc lanes arrive with the word, nothing here consumes them
  input  logic [igr_pkg::DATA_BYTES-1:0]                       i_rx_ecc,
  // ------------------------------------------------------------------------
  // packet buffer
  // ------------------------------------------------------------------------
  input  logic [igr_pkg::NUM_PORTS-1:0][igr_pkg::NUM_TC-1:0]   i_pb_xoff,
  output logic [igr_pkg::NUM_PORTS-1:0]                        o_pb_v,
  output logic [igr_pkg::NUM_PORTS-1:0][igr_pkg::DATA_W-1:0]   o_pb_data,
  output logic [igr_pkg::NUM_PORTS-1:0]                        o_pb_sop,
  output logic [igr_pkg::NUM_PORTS-1:0]                        o_pb_eop,
  output logic [igr_pkg::NUM_PORTS-1:0]                        o_pb_err,
  output logic [igr_pkg::NUM_PORTS-1:0][igr_pkg::TC_W-1:0]     o_pb_tc,
  output logic [igr_pkg::NUM_PORTS-1:0][igr_pkg::CNT_W-1:0]    o_pb_nbytes,
  output logic [igr_pkg::NUM_PORTS-1:0][igr_pkg::TS_W-1:0]     o_pb_ts,
  // ------------------------------------------------------------------------
  // transmit mac
  // ------------------------------------------------------------------------
  // tc0 sync pulse, once every NUM_TC cycles
  output logic                                                 o_tx_pfc_tc_sync,
  // [3]=port3 .. [0]=port0, class follows the sync phase
  output logic [igr_pkg::NUM_PORTS-1:0]                        o_tx_pfc_xoff
);

  import igr_pkg::*;

  // sync phase to the xoff serializer
  logic [TC_W-1:0] pfc_phase;

  // receive word to per-port hold registers
  igr_rx_demux u_rx_demux (
    .i_cclk        (i_cclk),
    .i_rst         (i_rst),
    .i_rx_port_num (i_rx_port_num),
    .i_rx_data_v   (i_rx_data_v),
    .i_rx_data     (i_rx_data),
    .i_rx_sop      (i_rx_sop),
    .i_rx_eop      (i_rx_eop),
    .i_rx_err      (i_rx_err),
    .i_rx_tc       (i_rx_tc),
    .i_rx_ts       (i_rx_ts),
    .o_pb_v        (o_pb_v),
    .o_pb_data     (o_pb_data),
    .o_pb_sop      (o_pb_sop),
    .o_pb_eop      (o_pb_eop),
    .o_pb_err      (o_pb_err),
    .o_pb_tc       (o_pb_tc),
    .o_pb_nbytes   (o_pb_nbytes),
    .o_pb_ts       (o_pb_ts)
  );

  // sync pulse goes to the mac and to the serializer
  igr_pfc_sync u_pfc_sync (
    .i_cclk    (i_cclk),
    .i_rst     (i_rst),
    .o_tc_sync (o_tx_pfc_tc_sync),
    .o_phase   (pfc_phase)
  );

  // pause levels in, per-port xoff strobe out
  igr_pfc_xoff u_pfc_xoff (
    .i_cclk        (i_cclk),
    .i_rst         (i_rst),
    .i_tc_sync     (o_tx_pfc_tc_sync),
    .i_phase       (pfc_phase),
    .i_pb_xoff     (i_pb_xoff),
    .o_tx_pfc_xoff (o_tx_pfc_xoff)
  );

endmodule

`default_nettype wire

// File: rtl/igr_pfc_sync.sv
//--------------------------------------------------------------------------
// free-running pfc sync, one pulse every NUM_TC cycles
// first pulse two cycles after the first edge that samples rst low
//--------------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module igr_pfc_sync (
  input  logic                      i_cclk,
  input  logic                      i_rst,
  output logic                      o_tc_sync,
  output logic [igr_pkg::TC_W-1:0]  o_phase
);

  import igr_pkg::*;

  logic              rst_q;
  logic              rel_q;
  logic [NUM_TC-1:0] ring_q;

  // delayed copy of reset, high one cycle longer than rst
  always_ff @(posedge i_cclk) begin
    rst_q <= i_rst;
  end

  // first cycle out of reset
  always_ff @(posedge i_cclk) begin
    if (i_rst) begin
      rel_q <= 1'b0;
    end else begin
      rel_q <= rst_q;
    end
  end

  // --------------------------------------------------------------------------
  // recirculating ring, seeded once by the release event
  // --------------------------------------------------------------------------

  always_ff @(posedge i_cclk) begin
    if (i_rst) begin
      ring_q <= '0;
    end else begin
      ring_q <= {ring_q[NUM_TC-2:0], rel_q | ring_q[NUM_TC-1]};
    end
  end

  // pulse to the tx mac, phase is 0 with the pulse then counts to 7
  always_ff @(posedge i_cclk) begin
    if (i_rst) begin
      o_tc_sync <= 1'b0;
      o_phase   <= '0;
    end else begin
      o_tc_sync <= ring_q[0];
      if (ring_q[0]) begin
        o_phase <= '0;
      end else begin
        o_phase <= o_phase + TC_W'(1);
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/igr_pfc_xoff.sv
//--------------------------------------------------------------------------
// per-port xoff strobe, one traffic class per cycle in sync phase order
// pause levels are taken one edge late, output is zero until first sync
//--------------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module igr_pfc_xoff (
  input  logic                                                 i_cclk,
  input  logic                                                 i_rst,
  // phase from the sync generator
  input  logic                                                 i_tc_sync,
  input  logic [igr_pkg::TC_W-1:0]                             i_phase,
  // pause levels from the packet buffer, [port][class]
  input  logic [igr_pkg::NUM_PORTS-1:0][igr_pkg::NUM_TC-1:0]   i_pb_xoff,
  // bit p is port p, class given by phase
  output logic [igr_pkg::NUM_PORTS-1:0]                        o_tx_pfc_xoff
);

  import igr_pkg::*;

  logic [NUM_PORTS-1:0][NUM_TC-1:0] xoff_q;
  logic                             armed_q;
  logic                             live;

  // --------------------------------------------------------------------------
  // pause level capture and arming
  // --------------------------------------------------------------------------

  // buffer pause levels, one cycle behind the packet buffer
  always_ff @(posedge i_cclk) begin
    xoff_q <= i_pb_xoff;
  end

  // phase is meaningless until the first sync pulse
  always_ff @(posedge i_cclk) begin
    if (i_rst) begin
      armed_q <= 1'b0;
    end else if (i_tc_sync) begin
      armed_q <= 1'b1;
    end
  end

  // the first pulse cycle itself already carries class 0
  assign live = armed_q | i_tc_sync;

  // --------------------------------------------------------------------------
  // class select by phase
  // --------------------------------------------------------------------------

  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      o_tx_pfc_xoff[p] = live & xoff_q[p][i_phase];
    end
  end

endmodule

`default_nettype wire

// File: rtl/igr_pkg.sv
//--------------------------------------------------------------------------
// sizing constants for the ingress data path and pause control block
// four logical ports, eight traffic classes, 64-bit words in eight lanes
//--------------------------------------------------------------------------

`default_nettype none

package igr_pkg;

  // ------------------------------------------------------------------------
  // port and traffic class sizing
  // ------------------------------------------------------------------------

  // logical ports behind one ingress block
  localparam int NUM_PORTS = 4;

  // port number width, indexes NUM_PORTS
  localparam int PORT_W = 2;

  // traffic classes, also the length of the pfc sync cycle
  localparam int NUM_TC = 8;

  // class index and sync phase width
  localparam int TC_W = 3;

  // ------------------------------------------------------------------------
  // receive word sizing
  // ------------------------------------------------------------------------

  // byte lanes per receive word
  localparam int DATA_BYTES = 8;

  // full word width
  localparam int DATA_W = DATA_BYTES * 8;

  // valid byte count, holds 0 to DATA_BYTES
  localparam int CNT_W = 4;

  // receive timestamp width
  localparam int TS_W = 32;

endpackage

`default_nettype wire

// File: rtl/igr_rx_demux.sv
//--------------------------------------------------------------------------
// two register stages from the port logic to the per-port hold registers
// a word is present when any byte-valid bit is set, no back-pressure
// held fields change only when their port accepts a word
//--------------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module igr_rx_demux (
  input  logic                                                 i_cclk,
  input  logic                                                 i_rst,
  // receive word from the port logic
  input  logic [igr_pkg::PORT_W-1:0]                           i_rx_port_num,
  input  logic [igr_pkg::DATA_BYTES-1:0]                       i_rx_data_v,
  input  logic [igr_pkg::DATA_W-1:0]                           i_rx_data,
  input  logic                                                 i_rx_sop,
  input  logic                                                 i_rx_eop,
  input  logic                                                 i_rx_err,
  input  logic [igr_pkg::TC_W-1:0]                             i_rx_tc,
  input  logic [igr_pkg::TS_W-1:0]                             i_rx_ts,
  // per-port words to the packet buffer
  output logic [igr_pkg::NUM_PORTS-1:0]                        o_pb_v,
  output logic [igr_pkg::NUM_PORTS-1:0][igr_pkg::DATA_W-1:0]   o_pb_data,
  output logic [igr_pkg::NUM_PORTS-1:0]                        o_pb_sop,
  output logic [igr_pkg::NUM_PORTS-1:0]                        o_pb_eop,
  output logic [igr_pkg::NUM_PORTS-1:0]                        o_pb_err,
  output logic [igr_pkg::NUM_PORTS-1:0][igr_pkg::TC_W-1:0]     o_pb_tc,
  output logic [igr_pkg::NUM_PORTS-1:0][igr_pkg::CNT_W-1:0]    o_pb_nbytes,
  output logic [igr_pkg::NUM_PORTS-1:0][igr_pkg::TS_W-1:0]     o_pb_ts
);

  import igr_pkg::*;

  // stage one, straight copy of the port logic word
  logic [PORT_W-1:0]     q1_port_num;
  logic [DATA_BYTES-1:0] q1_data_v;
  logic [DATA_W-1:0]     q1_data;
  logic                  q1_sop;
  logic                  q1_eop;
  logic                  q1_err;
  logic [TC_W-1:0]       q1_tc;
  logic [TS_W-1:0]       q1_ts;

  // stage one decode
  logic                  s1_present;
  logic [NUM_PORTS-1:0]  s1_port_oh;
  logic [NUM_PORTS-1:0]  s1_load;
  logic [CNT_W-1:0]      s1_nbytes;

  // population count of the byte-valid lanes
  function automatic logic [CNT_W-1:0] count_ones(input logic [DATA_BYTES-1:0] v);
    logic [CNT_W-1:0] n;
    n = '0;
    for (int b = 0; b < DATA_BYTES; b++) begin
      n = n + CNT_W'(v[b]);
    end
    return n;
  endfunction

  // --------------------------------------------------------------------------
  // stage one
  // --------------------------------------------------------------------------

  // stage one byte valids, no word right after reset
  always_ff @(posedge i_cclk) begin
    if (i_rst) begin
      q1_data_v <= '0;
    end else begin
      q1_data_v <= i_rx_data_v;
    end
  end

  // stage one word fields, qualified by q1_data_v
  always_ff @(posedge i_cclk) begin
    q1_port_num <= i_rx_port_num;
    q1_data     <= i_rx_data;
    q1_sop      <= i_rx_sop;
    q1_eop      <= i_rx_eop;
    q1_err      <= i_rx_err;
    q1_tc       <= i_rx_tc;
    q1_ts       <= i_rx_ts;
  end

  // any valid lane means a word
  assign s1_present = |q1_data_v;
  assign s1_nbytes  = count_ones(q1_data_v);

  // port number to one-hot
  always_comb begin
    s1_port_oh              = '0;
    s1_port_oh[q1_port_num] = 1'b1;
  end

  // only the addressed port loads, and only for a present word
  assign s1_load = s1_port_oh & {NUM_PORTS{s1_present}};

  // --------------------------------------------------------------------------
  // stage two, per-port hold registers
  // --------------------------------------------------------------------------

  // one-cycle strobe per accepted word, at most one port at a time
  always_ff @(posedge i_cclk) begin
    if (i_rst) begin
      o_pb_v <= '0;
    end else begin
      o_pb_v <= s1_load;
    end
  end

  // fields hold until the next word for the same port
  always_ff @(posedge i_cclk) begin
    if (i_rst) begin
      o_pb_data   <= '0;
      o_pb_sop    <= '0;
      o_pb_eop    <= '0;
      o_pb_err    <= '0;
      o_pb_tc     <= '0;
      o_pb_nbytes <= '0;
      o_pb_ts     <= '0;
    end else begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (s1_load[p]) begin
          o_pb_data[p]   <= q1_data;
          o_pb_sop[p]    <= q1_sop;
          o_pb_eop[p]    <= q1_eop;
          o_pb_err[p]    <= q1_err;
          o_pb_tc[p]     <= q1_tc;
          o_pb_nbytes[p] <= s1_nbytes;
          o_pb_ts[p]     <= q1_ts;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tb.f
rtl/igr_pkg.sv
rtl/igr_rx_demux.sv
rtl/igr_pfc_sync.sv
rtl/igr_pfc_xoff.sv
rtl/igr_dpc_top.sv
testbench/igr_dpc_assert.sv
testbench/tb_igr_dpc.sv

// File: testbench/igr_dpc_assert.sv
//--------------------------------------------------------------------------
// concurrent checks on the ingress top, attached by bind
// sync spacing is only checked outside reset
//--------------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module igr_dpc_assert (
  input logic                             i_cclk,
  input logic                             i_rst,
  input logic [igr_pkg::NUM_PORTS-1:0]    i_pb_v,
  input logic                             i_tc_sync,
  input logic [igr_pkg::NUM_PORTS-1:0]    i_xoff
);

  import igr_pkg::*;

  // number of failed assertions so far
  int fail_cnt = 0;

  // one port strobe at a time
  property one_port_valid;
    @(posedge i_cclk) disable iff (i_rst) $onehot0(i_pb_v);
  endproperty

  // seven quiet cycles, then the next pulse
  property sync_spacing;
    @(posedge i_cclk) disable iff (i_rst)
      i_tc_sync |-> ##1 (!i_tc_sync) [*7] ##1 i_tc_sync;
  endproperty

  // outputs idle once reset has been seen on two edges
  property quiet_in_reset;
    @(posedge i_cclk) (i_rst && $past(i_rst)) |->
      (i_pb_v == '0) && !i_tc_sync && (i_xoff == '0);
  endproperty

  a_one_port_valid: assert property (one_port_valid)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("more than one port valid strobe high");
    end
  a_sync_spacing: assert property (sync_spacing)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("sync pulse not eight cycles apart");
    end
  a_quiet_in_reset: assert property (quiet_in_reset)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("output active during reset");
    end

endmodule

bind igr_dpc_top igr_dpc_assert u_assert (
  .i_cclk    (i_cclk),
  .i_rst     (i_rst),
  .i_pb_v    (o_pb_v),
  .i_tc_sync (o_tx_pfc_tc_sync),
  .i_xoff    (o_tx_pfc_xoff)
);

`default_nettype wire

// File: testbench/tb_igr_dpc.sv
//--------------------------------------------------------------------------
// table driven testbench for the ingress data path and pause control
// inputs change on the falling edge, outputs are checked there too
//--------------------------------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module tb_igr_dpc;

  import igr_pkg::*;

  localparam int NROWS  = 21;
  localparam int NDRAIN = 12;
  localparam int LIMIT  = NROWS + NDRAIN + 64;

  logic                                 cclk;
  logic                                 rst;
  logic [PORT_W-1:0]                    rx_port_num;
  logic [DATA_BYTES-1:0]                rx_data_v;
  logic [DATA_W-1:0]                    rx_data;
  logic                                 rx_sop;
  logic                                 rx_eop;
  logic                                 rx_err;
  logic [TC_W-1:0]                      rx_tc;
  logic [TS_W-1:0]                      rx_ts;
  logic [DATA_BYTES-1:0]                rx_ecc;
  logic [NUM_PORTS-1:0][NUM_TC-1:0]     pb_xoff;
  logic [NUM_PORTS-1:0]                 pb_v;
  logic [NUM_PORTS-1:0][DATA_W-1:0]     pb_data;
  logic [NUM_PORTS-1:0]                 pb_sop;
  logic [NUM_PORTS-1:0]                 pb_eop;
  logic [NUM_PORTS-1:0]                 pb_err;
  logic [NUM_PORTS-1:0][TC_W-1:0]       pb_tc;
  logic [NUM_PORTS-1:0][CNT_W-1:0]      pb_nbytes;
  logic [NUM_PORTS-1:0][TS_W-1:0]       pb_ts;
  logic                                 tc_sync;
  logic [NUM_PORTS-1:0]                 xoff;

  // stimulus table
  string      t_name  [NROWS];
  int         t_port  [NROWS];
  logic [7:0] t_dv    [NROWS];
  logic       t_sop   [NROWS];
  logic       t_eop   [NROWS];
  logic       t_err   [NROWS];
  int         t_tc    [NROWS];
  logic [31:0] t_pause [NROWS];
  logic       t_rst   [NROWS];
  int         nrows;

  // words in flight, d1 sampled at the last edge, d2 one edge earlier
  string       d1_name;
  string       d2_name;
  int          d1_port;
  int          d2_port;
  logic [7:0]  d1_dv;
  logic [7:0]  d2_dv;
  logic [63:0] d1_data;
  logic [63:0] d2_data;
  logic        d1_sop;
  logic        d2_sop;
  logic        d1_eop;
  logic        d2_eop;
  logic        d1_err;
  logic        d2_err;
  int          d1_tc;
  int          d2_tc;
  logic [31:0] d1_ts;
  logic [31:0] d2_ts;
  logic        d1_rst;
  logic        d2_rst;
  logic [31:0] d1_pause;

  // per-port hold model
  logic [63:0] exp_data  [NUM_PORTS];
  logic        exp_sop   [NUM_PORTS];
  logic        exp_eop   [NUM_PORTS];
  logic        exp_err   [NUM_PORTS];
  int          exp_tc    [NUM_PORTS];
  int          exp_nbytes[NUM_PORTS];
  logic [31:0] exp_ts    [NUM_PORTS];

  int          lowcnt;
  int          errors;
  int          checks;
  int          cycles;
  int          seed;
  int          assert_fails;

  igr_dpc_top dut (
    .i_cclk           (cclk),
    .i_rst            (rst),
    .i_rx_port_num    (rx_port_num),
    .i_rx_data_v      (rx_data_v),
    .i_rx_data        (rx_data),
    .i_rx_sop         (rx_sop),
    .i_rx_eop         (rx_eop),
    .i_rx_err         (rx_err),
    .i_rx_tc          (rx_tc),
    .i_rx_ts          (rx_ts),
    .i_rx_ecc         (rx_ecc),
    .i_pb_xoff        (pb_xoff),
    .o_pb_v           (pb_v),
    .o_pb_data        (pb_data),
    .o_pb_sop         (pb_sop),
    .o_pb_eop         (pb_eop),
    .o_pb_err         (pb_err),
    .o_pb_tc          (pb_tc),
    .o_pb_nbytes      (pb_nbytes),
    .o_pb_ts          (pb_ts),
    .o_tx_pfc_tc_sync (tc_sync),
    .o_tx_pfc_xoff    (xoff)
  );

  // ------------------------------------------------------------------------
  // clock and run limit
  // ------------------------------------------------------------------------

  initial begin
    cclk = 1'b0;
    forever #2 cclk = ~cclk;
  end

  always @(posedge cclk) begin
    cycles = cycles + 1;
    if (cycles > LIMIT) begin
      $display("timeout after %0d cycles, stimulus did not finish", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  // ------------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------------

  task automatic add_row(input string name, input int port, input logic [7:0] dv,
                         input logic sop, input logic eop, input logic err,
                         input int tc, input logic [31:0] pause, input logic rst_v);
    t_name[nrows]  = name;
    t_port[nrows]  = port;
    t_dv[nrows]    = dv;
    t_sop[nrows]   = sop;
    t_eop[nrows]   = eop;
    t_err[nrows]   = err;
    t_tc[nrows]    = tc;
    t_pause[nrows] = pause;
    t_rst[nrows]   = rst_v;
    nrows = nrows + 1;
  endtask

  // number of set byte lanes
  function automatic int lanes_set(input logic [7:0] v);
    int n;
    n = 0;
    for (int i = 0; i < 8; i++) begin
      if (v[i]) n = n + 1;
    end
    return n;
  endfunction

  task automatic check_val(input string tname, input string field,
                           input logic [63:0] expv, input logic [63:0] actv);
    checks = checks + 1;
    if (actv !== expv) begin
      errors = errors + 1;
      $display("FAIL %s %s expected %h actual %h", tname, field, expv, actv);
    end
  endtask

  // drive one word and push it into the in-flight model
  task automatic drive_word(input string name, input int port, input logic [7:0] dv,
                            input logic sop, input logic eop, input logic err,
                            input int tc, input logic [31:0] pause, input logic rst_v);
    d2_name  = d1_name;
    d2_port  = d1_port;
    d2_dv    = d1_dv;
    d2_data  = d1_data;
    d2_sop   = d1_sop;
    d2_eop   = d1_eop;
    d2_err   = d1_err;
    d2_tc    = d1_tc;
    d2_ts    = d1_ts;
    d2_rst   = d1_rst;
    d1_name  = name;
    d1_port  = port;
    d1_dv    = dv;
    d1_data  = {$random(seed), $random(seed)};
    d1_sop   = sop;
    d1_eop   = eop;
    d1_err   = err;
    d1_tc    = tc;
    d1_ts    = $random(seed);
    d1_rst   = rst_v;
    d1_pause = pause;
    rst         = rst_v;
    rx_port_num = PORT_W'(port);
    rx_data_v   = dv;
    rx_data     = d1_data;
    rx_sop      = sop;
    rx_eop      = eop;
    rx_err      = err;
    rx_tc       = TC_W'(tc);
    rx_ts       = d1_ts;
    rx_ecc      = 8'(d1_data[7:0]);
    pb_xoff     = pause;
  endtask

  // outputs after the last rising edge against the model
  task automatic check_cycle();
    logic [NUM_PORTS-1:0] exp_v;
    logic [NUM_PORTS-1:0] exp_x;
    logic                 exp_sync;
    int                   k;
    exp_v = '0;
    exp_x = '0;
    if (d1_rst) begin
      lowcnt = 0;
      for (int p = 0; p < NUM_PORTS; p++) begin
        exp_data[p]   = '0;
        exp_sop[p]    = 1'b0;
        exp_eop[p]    = 1'b0;
        exp_err[p]    = 1'b0;
        exp_tc[p]     = 0;
        exp_nbytes[p] = 0;
        exp_ts[p]     = '0;
      end
    end else begin
      lowcnt = lowcnt + 1;
      // a word sampled one edge earlier outside reset lands now
      if (!d2_rst && (d2_dv != 8'h00)) begin
        exp_v[d2_port]      = 1'b1;
        exp_data[d2_port]   = d2_data;
        exp_sop[d2_port]    = d2_sop;
        exp_eop[d2_port]    = d2_eop;
        exp_err[d2_port]    = d2_err;
        exp_tc[d2_port]     = d2_tc;
        exp_nbytes[d2_port] = lanes_set(d2_dv);
        exp_ts[d2_port]     = d2_ts;
      end
    end
    // first pulse on the third low edge, then every NUM_TC
    k = (lowcnt >= 3) ? (lowcnt - 3) % NUM_TC : 0;
    exp_sync = (lowcnt >= 3) && (k == 0);
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (lowcnt >= 3) exp_x[p] = d1_pause[p * NUM_TC + k];
    end
    check_val(d2_name, "pb_v", 64'(exp_v), 64'(pb_v));
    for (int p = 0; p < NUM_PORTS; p++) begin
      check_val(d2_name, $sformatf("pb_data[%0d]", p), exp_data[p], pb_data[p]);
      check_val(d2_name, $sformatf("pb_sop[%0d]", p), 64'(exp_sop[p]), 64'(pb_sop[p]));
      check_val(d2_name, $sformatf("pb_eop[%0d]", p), 64'(exp_eop[p]), 64'(pb_eop[p]));
      check_val(d2_name, $sformatf("pb_err[%0d]", p), 64'(exp_err[p]), 64'(pb_err[p]));
      check_val(d2_name, $sformatf("pb_tc[%0d]", p), 64'(exp_tc[p]), 64'(pb_tc[p]));
      check_val(d2_name, $sformatf("pb_nbytes[%0d]", p), 64'(exp_nbytes[p]),
                64'(pb_nbytes[p]));
      check_val(d2_name, $sformatf("pb_ts[%0d]", p), 64'(exp_ts[p]), 64'(pb_ts[p]));
    end
    check_val(d1_name, "tc_sync", 64'(exp_sync), 64'(tc_sync));
    check_val(d1_name, "xoff", 64'(exp_x), 64'(xoff));
  endtask

  // ------------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------------

  initial begin
    seed = 32'h77639d02;
    errors = 0;
    checks = 0;
    cycles = 0;
    nrows = 0;
    lowcnt = 0;
    assert_fails = 0;
    rst = 1'b1;
    rx_port_num = '0;
    rx_data_v = '0;
    rx_data = '0;
    rx_sop = 1'b0;
    rx_eop = 1'b0;
    rx_err = 1'b0;
    rx_tc = '0;
    rx_ts = '0;
    rx_ecc = '0;
    pb_xoff = '0;
    // reset word already in the model for the first edge
    d1_name = "reset";
    d1_port = 0;
    d1_dv = '0;
    d1_data = '0;
    d1_sop = 1'b0;
    d1_eop = 1'b0;
    d1_err = 1'b0;
    d1_tc = 0;
    d1_ts = '0;
    d1_rst = 1'b1;
    d1_pause = '0;
    d2_name = "reset";
    d2_port = 0;
    d2_dv = '0;
    d2_data = '0;
    d2_sop = 1'b0;
    d2_eop = 1'b0;
    d2_err = 1'b0;
    d2_tc = 0;
    d2_ts = '0;
    d2_rst = 1'b1;

    //      name         port dv     sop   eop   err   tc pause         rst
    add_row("rst_a",     0, 8'h00, 1'b0, 1'b0, 1'b0, 0, 32'h0000_0000, 1'b1);
    add_row("p0_1b",     0, 8'h01, 1'b1, 1'b0, 1'b0, 1, 32'h8421_1248, 1'b0);
    add_row("p1_2b",     1, 8'h03, 1'b0, 1'b0, 1'b0, 2, 32'h0f0f_f0f0, 1'b0);
    add_row("p2_3b",     2, 8'h07, 1'b0, 1'b0, 1'b1, 3, 32'ha5a5_5a5a, 1'b0);
    add_row("p3_4b",     3, 8'h0f, 1'b0, 1'b1, 1'b0, 4, 32'hffff_0000, 1'b0);
    add_row("idle_a",    1, 8'h00, 1'b1, 1'b1, 1'b1, 7, 32'h1234_5678, 1'b0);
    add_row("p0_5b",     0, 8'h1f, 1'b0, 1'b0, 1'b0, 5, 32'h0000_ffff, 1'b0);
    add_row("p0_6b",     0, 8'h3f, 1'b0, 1'b1, 1'b0, 6, 32'hdead_beef, 1'b0);
    add_row("idle_b",    0, 8'h00, 1'b0, 1'b0, 1'b0, 2, 32'hc3c3_3c3c, 1'b0);
    add_row("p3_7b",     3, 8'h7f, 1'b1, 1'b1, 1'b0, 7, 32'h0123_4567, 1'b0);
    add_row("p2_8b",     2, 8'hff, 1'b1, 1'b0, 1'b0, 0, 32'h89ab_cdef, 1'b0);
    add_row("p1_8b",     1, 8'hff, 1'b0, 1'b1, 1'b1, 1, 32'h5555_aaaa, 1'b0);
    add_row("p2_lane",   2, 8'h80, 1'b0, 1'b1, 1'b0, 5, 32'h7e7e_8181, 1'b0);
    add_row("p1_sparse", 1, 8'h55, 1'b1, 1'b0, 1'b0, 3, 32'hf00f_0ff0, 1'b0);
    // words during a second reset are dropped
    add_row("rst_b0",    0, 8'hff, 1'b1, 1'b1, 1'b1, 6, 32'hffff_ffff, 1'b1);
    add_row("rst_b1",    3, 8'hff, 1'b1, 1'b0, 1'b0, 2, 32'hffff_ffff, 1'b1);
    add_row("post_idle", 2, 8'h00, 1'b0, 1'b0, 1'b0, 0, 32'h6969_9696, 1'b0);
    add_row("p1_after",  1, 8'h0f, 1'b1, 1'b0, 1'b0, 4, 32'h3333_cccc, 1'b0);
    add_row("p3_after",  3, 8'he0, 1'b0, 1'b1, 1'b0, 7, 32'h9999_6666, 1'b0);
    add_row("p0_back",   0, 8'h3c, 1'b1, 1'b1, 1'b0, 1, 32'h0ff0_f00f, 1'b0);
    add_row("p2_back",   2, 8'hc3, 1'b0, 1'b0, 1'b1, 6, 32'hface_cafe, 1'b0);

    for (int r = 0; r < nrows; r++) begin
      @(negedge cclk);
      check_cycle();
      drive_word(t_name[r], t_port[r], t_dv[r], t_sop[r], t_eop[r], t_err[r],
                 t_tc[r], t_pause[r], t_rst[r]);
    end
    // idle words with random pause levels to drain and watch sync
    for (int d = 0; d < NDRAIN; d++) begin
      @(negedge cclk);
      check_cycle();
      drive_word("drain", 0, 8'h00, 1'b0, 1'b0, 1'b0, 0, $random(seed), 1'b0);
    end
    @(negedge cclk);
    check_cycle();

    assert_fails = dut.u_assert.fail_cnt;
    $display("checks: %0d errors: %0d assertion failures: %0d",
             checks, errors, assert_fails);
    if ((errors == 0) && (assert_fails == 0)) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
